/* cache_mem_top.f */
+incdir+include
logic/cache_mem_pkg.sv
logic/tag_match.sv
logic/plru_tree.sv
logic/set_array.sv
logic/cache_mem_top.sv
tb/tb_cache_mem.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the cache array testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f cache_mem_top.f \
	--top-module tb_cache_mem \
	-o tb_cache_mem

./obj_dir/tb_cache_mem | tee sim.log

if grep -q "All tests passed" sim.log; then
	echo "simulation result: PASS"
else
	echo "simulation result: FAIL"
	exit 1
fi

/* tb/tb_cache_mem.sv */
// directed table then 300 random cycles on sets 1 and 6; expects a 4-way, 8-set geometry
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_cache_mem import cache_mem_pkg::*; ();

	localparam int DIR_ROWS    = 14;
	localparam int RAND_CYCLES = 300;
	localparam int MAX_CYCLES  = 4 + DIR_ROWS + RAND_CYCLES + 50;

	localparam cache_rd_req_t  NO_RD   = '0;
	localparam cache_wr_req_t  NO_WR   = '0;
	localparam cache_rd_resp_t NO_RESP = '0;
	localparam cache_victim_t  NO_VIC  = '0;

	typedef struct packed {
		cache_rd_req_t  rd1;
		cache_rd_req_t  rd2;
		cache_wr_req_t  wr;
		cache_rd_resp_t exp_rd1;
		cache_rd_resp_t exp_rd2;
		logic           exp_wr_miss;
		cache_victim_t  exp_victim;
	} dir_row_t;

	logic           clock = 1'b0;
	logic           reset;
	cache_rd_req_t  rd1_req;
	cache_rd_req_t  rd2_req;
	cache_wr_req_t  wr_req;
	cache_rd_resp_t rd1_resp;
	cache_rd_resp_t rd2_resp;
	cache_miss_t    rd1_miss;
	cache_miss_t    rd2_miss;
	cache_miss_t    wr_miss;
	cache_victim_t  victim;

	dir_row_t    rows [DIR_ROWS];
	int          row_fill     = 0;
	int          cycle_count  = 0;
	int          error_count  = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	logic [31:0] rng;

	// reference model state; tree bit 0 is the root, 1 the left pair, 2 the right pair
	logic        m_valid [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
	logic        m_dirty [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
	cache_tag_t  m_tag   [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
	cache_data_t m_data  [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
	logic [2:0]  m_tree  [`CACHE_NUM_SETS];

	cache_mem_top i_dut (
		.clock    (clock),
		.reset    (reset),
		.rd1_req  (rd1_req),
		.rd2_req  (rd2_req),
		.wr_req   (wr_req),
		.rd1_resp (rd1_resp),
		.rd2_resp (rd2_resp),
		.rd1_miss (rd1_miss),
		.rd2_miss (rd2_miss),
		.wr_miss  (wr_miss),
		.victim   (victim)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [`CACHE_ADDR_BITS-1:0] address(
		input cache_tag_t tag, input cache_idx_t idx, input logic [2:0] off);
		return {tag, idx, off};
	endfunction

	function automatic cache_rd_req_t read_at(input cache_tag_t tag, input cache_idx_t idx);
		cache_rd_req_t r;
		r.en       = 1'b1;
		r.addr.raw = address(tag, idx, 3'd5);
		return r;
	endfunction

	function automatic cache_wr_req_t write_at(input cache_tag_t tag, input cache_idx_t idx,
		input cache_data_t data, input logic dirty);
		cache_wr_req_t w;
		w.en       = 1'b1;
		w.addr.raw = address(tag, idx, 3'd2);
		w.data     = data;
		w.dirty    = dirty;
		return w;
	endfunction

	function automatic cache_rd_resp_t hit_with(input cache_data_t data);
		cache_rd_resp_t r;
		r.hit  = 1'b1;
		r.data = data;
		return r;
	endfunction

	// evicted line address always has a zero offset
	function automatic cache_victim_t evicted(input cache_tag_t tag, input cache_idx_t idx,
		input cache_data_t data, input logic dirty);
		cache_victim_t v;
		v.valid    = 1'b1;
		v.addr.raw = address(tag, idx, 3'd0);
		v.data     = data;
		v.dirty    = dirty;
		return v;
	endfunction

	task automatic add_row(input cache_rd_req_t r1, input cache_rd_req_t r2,
		input cache_wr_req_t w, input cache_rd_resp_t e1, input cache_rd_resp_t e2,
		input logic ewm, input cache_victim_t ev);
		rows[row_fill].rd1         = r1;
		rows[row_fill].rd2         = r2;
		rows[row_fill].wr          = w;
		rows[row_fill].exp_rd1     = e1;
		rows[row_fill].exp_rd2     = e2;
		rows[row_fill].exp_wr_miss = ewm;
		rows[row_fill].exp_victim  = ev;
		row_fill++;
	endtask

	task automatic build_table();
		// after reset everything misses
		add_row(read_at(10'd1, 3'd2), read_at(10'd7, 3'd5), NO_WR, NO_RESP, NO_RESP, 1'b0, NO_VIC);
		// write then read back, other tag misses
		add_row(NO_RD, NO_RD, write_at(10'd1, 3'd2, 64'h1111_0000_0000_0001, 1'b1),
			NO_RESP, NO_RESP, 1'b1, NO_VIC);
		add_row(read_at(10'd1, 3'd2), read_at(10'd2, 3'd2), NO_WR,
			hit_with(64'h1111_0000_0000_0001), NO_RESP, 1'b0, NO_VIC);
		// forwarding on rd1, old contents on rd2
		add_row(read_at(10'd3, 3'd2), read_at(10'd1, 3'd2),
			write_at(10'd3, 3'd2, 64'h2222_0000_0000_0002, 1'b0),
			hit_with(64'h2222_0000_0000_0002), hit_with(64'h1111_0000_0000_0001), 1'b1, NO_VIC);
		// fill set 5, ways 0 to 3
		add_row(NO_RD, NO_RD, write_at(10'd1, 3'd5, 64'h5001, 1'b1), NO_RESP, NO_RESP, 1'b1, NO_VIC);
		add_row(NO_RD, NO_RD, write_at(10'd2, 3'd5, 64'h5002, 1'b0), NO_RESP, NO_RESP, 1'b1, NO_VIC);
		add_row(NO_RD, NO_RD, write_at(10'd3, 3'd5, 64'h5003, 1'b1), NO_RESP, NO_RESP, 1'b1, NO_VIC);
		add_row(NO_RD, NO_RD, write_at(10'd4, 3'd5, 64'h5004, 1'b0), NO_RESP, NO_RESP, 1'b1, NO_VIC);
		// tree is all zero now, way 0 goes
		add_row(NO_RD, NO_RD, write_at(10'd5, 3'd5, 64'h5005, 1'b0), NO_RESP, NO_RESP, 1'b1,
			evicted(10'd1, 3'd5, 64'h5001, 1'b1));
		add_row(NO_RD, read_at(10'd5, 3'd5), write_at(10'd5, 3'd5, 64'h5055, 1'b1),
			NO_RESP, hit_with(64'h5055), 1'b0, NO_VIC);
		// rd1 touches way 1, rd2 way 2; root ends at the lower half
		add_row(read_at(10'd2, 3'd5), read_at(10'd3, 3'd5), NO_WR,
			hit_with(64'h5002), hit_with(64'h5003), 1'b0, NO_VIC);
		add_row(NO_RD, NO_RD, write_at(10'd6, 3'd5, 64'h5006, 1'b0), NO_RESP, NO_RESP, 1'b1,
			evicted(10'd5, 3'd5, 64'h5055, 1'b1));
		// write fills way 3, same-cycle read of way 0 overrides the root
		add_row(read_at(10'd6, 3'd5), NO_RD, write_at(10'd7, 3'd5, 64'h5007, 1'b1),
			hit_with(64'h5006), NO_RESP, 1'b1, evicted(10'd4, 3'd5, 64'h5004, 1'b0));
		add_row(NO_RD, read_at(10'd4, 3'd5), write_at(10'd8, 3'd5, 64'h5008, 1'b0),
			NO_RESP, NO_RESP, 1'b1, evicted(10'd3, 3'd5, 64'h5003, 1'b1));
	endtask

	function automatic way_idx_t plru_pick(input logic [2:0] t);
		if (!t[0]) begin
			return t[1] ? way_idx_t'(1) : way_idx_t'(0);
		end
		return t[2] ? way_idx_t'(3) : way_idx_t'(2);
	endfunction

	// path bits point away from the touched way
	function automatic logic [2:0] plru_mark(input logic [2:0] t, input way_idx_t way);
		logic [2:0] r;
		r    = t;
		r[0] = ~way[1];
		if (!way[1]) begin
			r[1] = ~way[0];
		end else begin
			r[2] = ~way[0];
		end
		return r;
	endfunction

	function automatic logic stored_hit(input cache_addr_u a, output way_idx_t way);
		logic found;
		found = 1'b0;
		way   = '0;
		for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
			if (m_valid[a.fields.idx][w] && m_tag[a.fields.idx][w] == a.fields.tag) begin
				found = 1'b1;
				way   = way_idx_t'(w);
			end
		end
		return found;
	endfunction

	function automatic way_idx_t fill_choice(input cache_wr_req_t w);
		way_idx_t hit_way;
		way_idx_t fill;
		if (stored_hit(w.addr, hit_way)) begin
			return hit_way;
		end
		fill = plru_pick(m_tree[w.addr.fields.idx]);
		for (int k = `CACHE_NUM_WAYS - 1; k >= 0; k--) begin
			if (!m_valid[w.addr.fields.idx][k]) begin
				fill = way_idx_t'(k);
			end
		end
		return fill;
	endfunction

	function automatic cache_rd_resp_t read_expect(input cache_rd_req_t r, input cache_wr_req_t w);
		way_idx_t way;
		if (r.en && w.en && r.addr.fields.tag == w.addr.fields.tag &&
			r.addr.fields.idx == w.addr.fields.idx) begin
			return hit_with(w.data);
		end
		if (r.en && stored_hit(r.addr, way)) begin
			return hit_with(m_data[r.addr.fields.idx][way]);
		end
		return NO_RESP;
	endfunction

	task automatic predict(input cache_rd_req_t r1, input cache_rd_req_t r2,
		input cache_wr_req_t w, output cache_rd_resp_t e1, output cache_rd_resp_t e2,
		output logic ewm, output cache_victim_t ev);
		way_idx_t   way;
		way_idx_t   fill;
		cache_idx_t idx;
		idx  = w.addr.fields.idx;
		e1   = read_expect(r1, w);
		e2   = read_expect(r2, w);
		ewm  = w.en && !stored_hit(w.addr, way);
		fill = fill_choice(w);
		ev   = NO_VIC;
		if (ewm && m_valid[idx][fill]) begin
			ev = evicted(m_tag[idx][fill], idx, m_data[idx][fill], m_dirty[idx][fill]);
		end
	endtask

	// a read that hits only through forwarding leaves the tree alone
	task automatic model_update(input cache_rd_req_t r1, input cache_rd_req_t r2,
		input cache_wr_req_t w);
		way_idx_t   way1;
		way_idx_t   way2;
		way_idx_t   fill;
		logic       hit1;
		logic       hit2;
		cache_idx_t idx;
		idx  = w.addr.fields.idx;
		hit1 = r1.en && stored_hit(r1.addr, way1);
		hit2 = r2.en && stored_hit(r2.addr, way2);
		fill = fill_choice(w);
		if (w.en) begin
			m_tree[idx] = plru_mark(m_tree[idx], fill);
		end
		if (hit1) begin
			m_tree[r1.addr.fields.idx] = plru_mark(m_tree[r1.addr.fields.idx], way1);
		end
		if (hit2) begin
			m_tree[r2.addr.fields.idx] = plru_mark(m_tree[r2.addr.fields.idx], way2);
		end
		if (w.en) begin
			m_valid[idx][fill] = 1'b1;
			m_dirty[idx][fill] = w.dirty;
			m_tag[idx][fill]   = w.addr.fields.tag;
			m_data[idx][fill]  = w.data;
		end
	endtask

	task automatic apply_cycle(input cache_rd_req_t r1, input cache_rd_req_t r2,
		input cache_wr_req_t w);
		@(posedge clock);
		rd1_req <= r1;
		rd2_req <= r2;
		wr_req  <= w;
		@(negedge clock);
	endtask

	task automatic compare_outputs(input cache_rd_req_t r1, input cache_rd_req_t r2,
		input cache_wr_req_t w, input cache_rd_resp_t e1, input cache_rd_resp_t e2,
		input logic ewm, input cache_victim_t ev, output int errs);
		cache_miss_t m1;
		cache_miss_t m2;
		cache_miss_t mw;
		errs     = 0;
		m1.valid = r1.en && !e1.hit;
		m1.addr  = r1.addr;
		m2.valid = r2.en && !e2.hit;
		m2.addr  = r2.addr;
		mw.valid = ewm;
		mw.addr  = w.addr;
		if (rd1_resp !== e1) begin
			$display("Mismatch at %0t: rd1_resp %h, expected %h", $time, rd1_resp, e1);
			errs++;
		end
		if (rd2_resp !== e2) begin
			$display("Mismatch at %0t: rd2_resp %h, expected %h", $time, rd2_resp, e2);
			errs++;
		end
		if (rd1_miss !== m1) begin
			$display("Mismatch at %0t: rd1_miss %h, expected %h", $time, rd1_miss, m1);
			errs++;
		end
		if (rd2_miss !== m2) begin
			$display("Mismatch at %0t: rd2_miss %h, expected %h", $time, rd2_miss, m2);
			errs++;
		end
		if (wr_miss !== mw) begin
			$display("Mismatch at %0t: wr_miss %h, expected %h", $time, wr_miss, mw);
			errs++;
		end
		if (victim !== ev) begin
			$display("Mismatch at %0t: victim %h, expected %h", $time, victim, ev);
			errs++;
		end
	endtask

	initial begin
		cache_rd_req_t  r1;
		cache_rd_req_t  r2;
		cache_wr_req_t  w;
		cache_rd_resp_t e1;
		cache_rd_resp_t e2;
		logic           ewm;
		cache_victim_t  ev;
		int             errs;
		int             rand_errs;
		reset   = 1'b1;
		rd1_req = '0;
		rd2_req = '0;
		wr_req  = '0;
		rng     = 32'd31458;
		for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
			m_tree[s] = '0;
			for (int k = 0; k < `CACHE_NUM_WAYS; k++) begin
				m_valid[s][k] = 1'b0;
				m_dirty[s][k] = 1'b0;
			end
		end
		build_table();
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		for (int i = 0; i < DIR_ROWS; i++) begin
			apply_cycle(rows[i].rd1, rows[i].rd2, rows[i].wr);
			compare_outputs(rows[i].rd1, rows[i].rd2, rows[i].wr, rows[i].exp_rd1,
				rows[i].exp_rd2, rows[i].exp_wr_miss, rows[i].exp_victim, errs);
			model_update(rows[i].rd1, rows[i].rd2, rows[i].wr);
			tests_run++;
			error_count += errs;
			if (errs != 0) begin
				tests_failed++;
				$display("directed row %0d: FAILED with %0d mismatches", i, errs);
			end else begin
				$display("directed row %0d: ok", i);
			end
		end

		// two sets, six tags, so evictions are frequent
		rand_errs = 0;
		for (int c = 0; c < RAND_CYCLES; c++) begin
			rng = xorshift(rng);
			r1.en       = rng[0];
			r1.addr.raw = address(cache_tag_t'(rng[7:4] % 4'd6), rng[8] ? 3'd1 : 3'd6, rng[11:9]);
			r2.en       = rng[1];
			r2.addr.raw = address(cache_tag_t'(rng[15:12] % 4'd6), rng[16] ? 3'd1 : 3'd6,
				rng[19:17]);
			w.en        = rng[2];
			w.addr.raw  = address(cache_tag_t'(rng[23:20] % 4'd6), rng[24] ? 3'd1 : 3'd6,
				rng[27:25]);
			w.dirty     = rng[28];
			rng         = xorshift(rng);
			w.data[63:32] = rng;
			rng         = xorshift(rng);
			w.data[31:0]  = rng;
			apply_cycle(r1, r2, w);
			predict(r1, r2, w, e1, e2, ewm, ev);
			compare_outputs(r1, r2, w, e1, e2, ewm, ev, errs);
			model_update(r1, r2, w);
			rand_errs += errs;
		end
		tests_run++;
		error_count += rand_errs;
		if (rand_errs != 0) begin
			tests_failed++;
			$display("random phase: FAILED with %0d mismatches", rand_errs);
		end else begin
			$display("random phase: ok, %0d cycles", RAND_CYCLES);
		end

		$display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
			error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* logic/cache_mem_top.sv */
// cache data array top; no handshake, every enabled request is taken in its own cycle
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_mem_top import cache_mem_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  cache_rd_req_t  rd1_req,
	input  cache_rd_req_t  rd2_req,
	input  cache_wr_req_t  wr_req,
	output cache_rd_resp_t rd1_resp,
	output cache_rd_resp_t rd2_resp,
	output cache_miss_t    rd1_miss,
	output cache_miss_t    rd2_miss,
	output cache_miss_t    wr_miss,
	output cache_victim_t  victim
);

	cache_set_tags_t            rd1_tags;
	cache_set_tags_t            rd2_tags;
	cache_set_tags_t            wr_tags;
	logic [`CACHE_NUM_WAYS-1:0] rd1_valid;
	logic [`CACHE_NUM_WAYS-1:0] rd2_valid;
	logic [`CACHE_NUM_WAYS-1:0] wr_valid;

	logic     rd1_hit;
	logic     rd2_hit;
	logic     wr_hit;
	way_idx_t rd1_hit_way;
	way_idx_t rd2_hit_way;
	way_idx_t wr_hit_way;
	way_idx_t repl_way;
	way_idx_t fill_way;

	tag_match u_match_rd1 (
		.set_tags  (rd1_tags),
		.set_valid (rd1_valid),
		.tag       (rd1_req.addr.fields.tag),
		.en        (rd1_req.en),
		.hit       (rd1_hit),
		.hit_way   (rd1_hit_way)
	);

	tag_match u_match_rd2 (
		.set_tags  (rd2_tags),
		.set_valid (rd2_valid),
		.tag       (rd2_req.addr.fields.tag),
		.en        (rd2_req.en),
		.hit       (rd2_hit),
		.hit_way   (rd2_hit_way)
	);

	tag_match u_match_wr (
		.set_tags  (wr_tags),
		.set_valid (wr_valid),
		.tag       (wr_req.addr.fields.tag),
		.en        (wr_req.en),
		.hit       (wr_hit),
		.hit_way   (wr_hit_way)
	);

	// read misses leave the tree alone
	plru_tree u_plru (
		.clock    (clock),
		.reset    (reset),
		.wr_en    (wr_req.en),
		.wr_idx   (wr_req.addr.fields.idx),
		.wr_way   (fill_way),
		.rd1_en   (rd1_hit),
		.rd1_idx  (rd1_req.addr.fields.idx),
		.rd1_way  (rd1_hit_way),
		.rd2_en   (rd2_hit),
		.rd2_idx  (rd2_req.addr.fields.idx),
		.rd2_way  (rd2_hit_way),
		.repl_way (repl_way)
	);

	set_array u_array (
		.clock       (clock),
		.reset       (reset),
		.rd1_req     (rd1_req),
		.rd2_req     (rd2_req),
		.wr_req      (wr_req),
		.rd1_hit     (rd1_hit),
		.rd2_hit     (rd2_hit),
		.wr_hit      (wr_hit),
		.rd1_hit_way (rd1_hit_way),
		.rd2_hit_way (rd2_hit_way),
		.wr_hit_way  (wr_hit_way),
		.repl_way    (repl_way),
		.rd1_tags    (rd1_tags),
		.rd2_tags    (rd2_tags),
		.wr_tags     (wr_tags),
		.rd1_valid   (rd1_valid),
		.rd2_valid   (rd2_valid),
		.wr_valid    (wr_valid),
		.fill_way    (fill_way),
		.rd1_resp    (rd1_resp),
		.rd2_resp    (rd2_resp),
		.rd1_miss    (rd1_miss),
		.rd2_miss    (rd2_miss),
		.wr_miss     (wr_miss),
		.victim      (victim)
	);

endmodule

/* logic/set_array.sv */
// line storage for all sets; read data and victim payload read as zero when not valid
`timescale 1ns/1ps
`include "cache_defs.svh"

module set_array import cache_mem_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  cache_rd_req_t              rd1_req,
	input  cache_rd_req_t              rd2_req,
	input  cache_wr_req_t              wr_req,
	input  logic                       rd1_hit,
	input  logic                       rd2_hit,
	input  logic                       wr_hit,
	input  way_idx_t                   rd1_hit_way,
	input  way_idx_t                   rd2_hit_way,
	input  way_idx_t                   wr_hit_way,
	input  way_idx_t                   repl_way,
	output cache_set_tags_t            rd1_tags,
	output cache_set_tags_t            rd2_tags,
	output cache_set_tags_t            wr_tags,
	output logic [`CACHE_NUM_WAYS-1:0] rd1_valid,
	output logic [`CACHE_NUM_WAYS-1:0] rd2_valid,
	output logic [`CACHE_NUM_WAYS-1:0] wr_valid,
	output way_idx_t                   fill_way,
	output cache_rd_resp_t             rd1_resp,
	output cache_rd_resp_t             rd2_resp,
	output cache_miss_t                rd1_miss,
	output cache_miss_t                rd2_miss,
	output cache_miss_t                wr_miss,
	output cache_victim_t              victim
);

	cache_line_t lines [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];

	cache_idx_t  rd1_idx;
	cache_idx_t  rd2_idx;
	cache_idx_t  wr_idx;
	cache_addr_u vic_addr;

	assign rd1_idx = rd1_req.addr.fields.idx;
	assign rd2_idx = rd2_req.addr.fields.idx;
	assign wr_idx  = wr_req.addr.fields.idx;

	// read port result, write data wins on a same-line match
	function automatic cache_rd_resp_t read_resp(
		input cache_rd_req_t req,
		input cache_wr_req_t wr,
		input logic          hit,
		input cache_data_t   stored
	);
		cache_rd_resp_t resp;
		logic           fwd;
		fwd  = req.en && wr.en && (req.addr.fields.tag == wr.addr.fields.tag) &&
			(req.addr.fields.idx == wr.addr.fields.idx);
		resp = '0;
		if (fwd) begin
			resp.hit  = 1'b1;
			resp.data = wr.data;
		end else if (hit) begin
			resp.hit  = 1'b1;
			resp.data = stored;
		end
		return resp;
	endfunction

	// tag and valid views of the three addressed sets
	always_comb begin
		for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
			rd1_tags[w]  = lines[rd1_idx][w].tag;
			rd2_tags[w]  = lines[rd2_idx][w].tag;
			wr_tags[w]   = lines[wr_idx][w].tag;
			rd1_valid[w] = lines[rd1_idx][w].valid;
			rd2_valid[w] = lines[rd2_idx][w].valid;
			wr_valid[w]  = lines[wr_idx][w].valid;
		end
	end

	// hit way, else lowest invalid, else PLRU
	always_comb begin
		fill_way = repl_way;
		if (wr_hit) begin
			fill_way = wr_hit_way;
		end else begin
			for (int w = `CACHE_NUM_WAYS - 1; w >= 0; w--) begin
				if (!wr_valid[w]) begin
					fill_way = way_idx_t'(w);
				end
			end
		end
	end

	assign rd1_resp = read_resp(rd1_req, wr_req, rd1_hit, lines[rd1_idx][rd1_hit_way].data);
	assign rd2_resp = read_resp(rd2_req, wr_req, rd2_hit, lines[rd2_idx][rd2_hit_way].data);

	assign rd1_miss = '{valid: rd1_req.en && !rd1_resp.hit, addr: rd1_req.addr};
	assign rd2_miss = '{valid: rd2_req.en && !rd2_resp.hit, addr: rd2_req.addr};
	assign wr_miss  = '{valid: wr_req.en && !wr_hit, addr: wr_req.addr};

	// victim address from stored tag and set index
	always_comb begin
		vic_addr            = '0;
		vic_addr.fields.tag = lines[wr_idx][fill_way].tag;
		vic_addr.fields.idx = wr_idx;
	end

	always_comb begin
		victim = '0;
		if (wr_req.en && !wr_hit && wr_valid[fill_way]) begin
			victim.valid    = 1'b1;
			victim.addr.raw = vic_addr.raw;
			victim.data     = lines[wr_idx][fill_way].data;
			victim.dirty    = lines[wr_idx][fill_way].dirty;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
				for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
					lines[s][w].valid <= 1'b0;
					lines[s][w].dirty <= 1'b0;
				end
			end
		end else if (wr_req.en) begin
			lines[wr_idx][fill_way].data  <= wr_req.data;
			lines[wr_idx][fill_way].tag   <= wr_req.addr.fields.tag;
			lines[wr_idx][fill_way].valid <= 1'b1;
			lines[wr_idx][fill_way].dirty <= wr_req.dirty;
		end
	end

endmodule

/* logic/plru_tree.sv */
// tree PLRU per set; updates from write, rd1, rd2 land in that order at one edge
`timescale 1ns/1ps
`include "cache_defs.svh"

module plru_tree import cache_mem_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       wr_en,
	input  cache_idx_t wr_idx,
	input  way_idx_t   wr_way,
	input  logic       rd1_en,
	input  cache_idx_t rd1_idx,
	input  way_idx_t   rd1_way,
	input  logic       rd2_en,
	input  cache_idx_t rd2_idx,
	input  way_idx_t   rd2_way,
	output way_idx_t   repl_way
);

	localparam int LEVELS = $clog2(`CACHE_NUM_WAYS);

	// heap order per set: node 0 is the root, children of n are 2n+1 and 2n+2
	logic [`CACHE_NUM_WAYS-2:0] tree      [`CACHE_NUM_SETS];
	logic [`CACHE_NUM_WAYS-2:0] tree_next [`CACHE_NUM_SETS];

	// point every node on the way's path at the other half
	function automatic logic [`CACHE_NUM_WAYS-2:0] plru_touch(
		input logic [`CACHE_NUM_WAYS-2:0] bits,
		input way_idx_t                   way
	);
		logic [`CACHE_NUM_WAYS-2:0] res;
		int                         node;
		logic                       b;
		res  = bits;
		node = 0;
		for (int lvl = 0; lvl < LEVELS; lvl++) begin
			b         = way[LEVELS-1-lvl];
			res[node] = ~b;
			node      = 2 * node + 1 + int'(b);
		end
		return res;
	endfunction

	// follow the bits down, zero goes to the lower half
	function automatic way_idx_t plru_victim(input logic [`CACHE_NUM_WAYS-2:0] bits);
		way_idx_t way;
		int       node;
		logic     b;
		way  = '0;
		node = 0;
		for (int lvl = 0; lvl < LEVELS; lvl++) begin
			b    = bits[node];
			way  = way_idx_t'({way, b});
			node = 2 * node + 1 + int'(b);
		end
		return way;
	endfunction

	always_comb begin
		tree_next = tree;
		if (wr_en) begin
			tree_next[wr_idx] = plru_touch(tree_next[wr_idx], wr_way);
		end
		// same set: later port overwrites shared path bits
		if (rd1_en) begin
			tree_next[rd1_idx] = plru_touch(tree_next[rd1_idx], rd1_way);
		end
		if (rd2_en) begin
			tree_next[rd2_idx] = plru_touch(tree_next[rd2_idx], rd2_way);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
				tree[s] <= '0;
			end
		end else begin
			tree <= tree_next;
		end
	end

	// from the current state, not this cycle's updates
	assign repl_way = plru_victim(tree[wr_idx]);

endmodule

/* logic/tag_match.sv */
// one-cycle tag compare for a set; assumes at most one valid way holds any given tag
`timescale 1ns/1ps
`include "cache_defs.svh"

module tag_match import cache_mem_pkg::*; (
	input  cache_set_tags_t            set_tags,
	input  logic [`CACHE_NUM_WAYS-1:0] set_valid,
	input  cache_tag_t                 tag,
	input  logic                       en,
	output logic                       hit,
	output way_idx_t                   hit_way
);

	logic [`CACHE_NUM_WAYS-1:0] way_hits;

	// CAM style compare, one line per way
	always_comb begin
		for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
			way_hits[w] = en && set_valid[w] && (set_tags[w] == tag);
		end
	end

	assign hit = |way_hits;

	// one-hot to binary, zero when nothing matches
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
			if (way_hits[w]) begin
				hit_way = hit_way | way_idx_t'(w);
			end
		end
	end

endmodule

/* logic/cache_mem_pkg.sv */
// shared cache types; offset width is whatever the address leaves after tag and index
`include "cache_defs.svh"

package cache_mem_pkg;

	typedef logic [`CACHE_TAG_BITS-1:0]  cache_tag_t;
	typedef logic [`CACHE_IDX_BITS-1:0]  cache_idx_t;
	typedef logic [`CACHE_DATA_BITS-1:0] cache_data_t;
	typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] way_idx_t;

	// tags of every way in one set
	typedef logic [`CACHE_NUM_WAYS-1:0][`CACHE_TAG_BITS-1:0] cache_set_tags_t;

	typedef struct packed {
		cache_tag_t tag;
		cache_idx_t idx;
		logic [`CACHE_ADDR_BITS-`CACHE_TAG_BITS-`CACHE_IDX_BITS-1:0] offset;
	} cache_addr_fields_t;

	// raw word as seen by the bus, fields as seen by the array
	typedef union packed {
		logic [`CACHE_ADDR_BITS-1:0] raw;
		cache_addr_fields_t          fields;
	} cache_addr_u;

	typedef struct packed {
		cache_data_t data;
		cache_tag_t  tag;
		logic        valid;
		logic        dirty;
	} cache_line_t;

	typedef struct packed {
		logic        en;
		cache_addr_u addr;
	} cache_rd_req_t;

	typedef struct packed {
		logic        en;
		cache_addr_u addr;
		cache_data_t data;
		logic        dirty;
	} cache_wr_req_t;

	typedef struct packed {
		logic        hit;
		cache_data_t data;
	} cache_rd_resp_t;

	typedef struct packed {
		logic        valid;
		cache_addr_u addr;
	} cache_miss_t;

	// evicted line, address carries a zero offset
	typedef struct packed {
		logic        valid;
		cache_addr_u addr;
		cache_data_t data;
		logic        dirty;
	} cache_victim_t;

endpackage

/* include/cache_defs.svh */
// cache geometry; tag, index and byte offset together must fill the address exactly
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// sets in the array
`define CACHE_NUM_SETS  8

// ways per set, must be a power of two for the PLRU tree
`define CACHE_NUM_WAYS  4

// address split
`define CACHE_IDX_BITS  3
`define CACHE_TAG_BITS  10
`define CACHE_ADDR_BITS 16

// one word per line
`define CACHE_DATA_BITS 64

`endif
